// File: source/hbus_pkg.sv
// Shared constants, vector types, controller states and bus structs
package hbus_pkg;

    // Subsystem geometry
    localparam int NUM_CHAN = 2;
    localparam int CHAN_SEL_BIT = 24;

    // Protocol timing in clk cycles
    localparam int TACC_COUNT = 5;
    localparam int RESET_COUNT = 4;
    localparam int TIMEOUT_COUNT = 32;

    // Longest read burst and read FIFO depth
    localparam int MAX_BURST = 16;

    // Shared controller counter must hold the timeout and the doubled latency
    localparam int CNT_W = $clog2(TIMEOUT_COUNT + 2 * TACC_COUNT);
    localparam int PTR_W = $clog2(MAX_BURST);
    localparam int FILL_W = $clog2(MAX_BURST + 1);

    typedef logic [31:0] addr_t;
    typedef logic [15:0] word_t;
    typedef logic [4:0] len_t;
    typedef logic [0:0] chan_t;
    typedef logic [CNT_W-1:0] cnt_t;
    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [FILL_W-1:0] fill_t;

    typedef enum logic [2:0] {
        RESET,
        IDLE,
        COMMAND,
        LATENCY,
        READ,
        WRITE,
        ERROR
    } ctrl_state_e;

    typedef struct packed {
        logic  write;
        logic  reg_space;
        addr_t addr;
        len_t  len;
        word_t wdata;
    } hbus_req_t;

    typedef struct packed {
        chan_t chan;
        word_t data;
    } hbus_rsp_t;

    // Pins driven by the controller
    typedef struct packed {
        logic       ck;
        logic       csn;
        logic       rstn;
        word_t      dq;
        logic       dq_oe;
        logic [1:0] rwds;
        logic       rwds_oe;
    } hbus_pins_o_t;

    // Pins driven by the device
    typedef struct packed {
        word_t dq;
        logic  rwds;
    } hbus_pins_i_t;

endpackage

// File: source/hbus_req_dispatch.sv
// Request dispatcher that steers each request to a channel by address bit
`timescale 1ns/1ps

module hbus_req_dispatch (
    input  logic                          clk,
    input  logic                          rst,
    input  hbus_pkg::hbus_req_t           req_i,
    input  logic                          req_valid_i,
    input  logic [hbus_pkg::NUM_CHAN-1:0] chan_ready_i,
    output logic                          req_ready_o,
    output hbus_pkg::hbus_req_t           chan_req_o,
    output logic [hbus_pkg::NUM_CHAN-1:0] chan_valid_o
);

    hbus_pkg::chan_t sel;

    // Target channel comes straight from the address
    assign sel = req_i.addr[hbus_pkg::CHAN_SEL_BIT];

    // All channels see the payload, only the selected one sees valid
    assign chan_req_o = req_i;

    always_comb begin
        for (int c = 0; c < hbus_pkg::NUM_CHAN; c++) begin
            chan_valid_o[c] = req_valid_i && (sel == hbus_pkg::chan_t'(c));
        end
    end

    // Ready follows the selected channel without a register stage
    assign req_ready_o = chan_ready_i[sel];

    // A request never reaches two controllers at once
    a_one_chan_valid: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(chan_valid_o)
    ) else $error("more than one channel valid");

endmodule

// File: source/hbus_channel_ctrl.sv
// HyperBus protocol engine for one channel with reset, command, latency and data phases
`timescale 1ns/1ps

module hbus_channel_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  hbus_pkg::hbus_req_t    req_i,
    input  logic                   req_valid_i,
    input  logic                   space_i,
    input  hbus_pkg::hbus_pins_i_t pins_i,
    output logic                   req_ready_o,
    output hbus_pkg::hbus_pins_o_t pins_o,
    output hbus_pkg::word_t        rd_word_o,
    output logic                   rd_valid_o,
    output logic                   error_o
);

    hbus_pkg::ctrl_state_e state_q;
    hbus_pkg::cnt_t        cnt_q;
    hbus_pkg::len_t        left_q;
    logic                  write_q;
    hbus_pkg::word_t       wdata_q;
    logic [47:0]           ca_q;
    logic [47:0]           ca_init;
    logic                  accept;
    logic                  bus_active;
    logic                  strobe;
    logic                  timeout;

    // Reads also need an empty FIFO with no word still on its way into it
    assign req_ready_o = (state_q == hbus_pkg::IDLE) &&
                         (req_i.write || (space_i && !rd_valid_o));
    assign accept = req_valid_i && req_ready_o;

    // Command/address word for the incoming request, always a linear burst
    assign ca_init = {~req_i.write, req_i.reg_space, 1'b1, req_i.addr[31:3],
                      13'd0, req_i.addr[2:0]};

    assign bus_active = state_q inside {hbus_pkg::COMMAND, hbus_pkg::LATENCY,
                                        hbus_pkg::READ, hbus_pkg::WRITE};

    assign strobe = (state_q == hbus_pkg::READ) && pins_i.rwds;
    assign timeout = (state_q == hbus_pkg::READ) && !pins_i.rwds && (cnt_q == '0);
    assign error_o = (state_q == hbus_pkg::ERROR);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= hbus_pkg::RESET;
            cnt_q <= hbus_pkg::cnt_t'(hbus_pkg::RESET_COUNT - 1);
            left_q <= '0;
            write_q <= 1'b0;
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= strobe;
            case (state_q)
                hbus_pkg::RESET: begin
                    if (cnt_q == '0) begin
                        state_q <= hbus_pkg::IDLE;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                hbus_pkg::IDLE: begin
                    if (accept) begin
                        left_q <= req_i.len;
                        write_q <= req_i.write;
                        // Three command beats
                        cnt_q <= hbus_pkg::cnt_t'(2);
                        state_q <= hbus_pkg::COMMAND;
                    end
                end
                hbus_pkg::COMMAND: begin
                    if (cnt_q == '0) begin
                        // Device asks for double latency by holding RWDS high
                        if (pins_i.rwds) begin
                            cnt_q <= hbus_pkg::cnt_t'(2 * hbus_pkg::TACC_COUNT - 1);
                        end else begin
                            cnt_q <= hbus_pkg::cnt_t'(hbus_pkg::TACC_COUNT - 1);
                        end
                        state_q <= hbus_pkg::LATENCY;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                hbus_pkg::LATENCY: begin
                    if (cnt_q == '0) begin
                        if (write_q) begin
                            state_q <= hbus_pkg::WRITE;
                        end else begin
                            cnt_q <= hbus_pkg::cnt_t'(hbus_pkg::TIMEOUT_COUNT - 1);
                            state_q <= hbus_pkg::READ;
                        end
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                hbus_pkg::READ: begin
                    if (strobe) begin
                        // Each strobe restarts the timeout window
                        cnt_q <= hbus_pkg::cnt_t'(hbus_pkg::TIMEOUT_COUNT - 1);
                        left_q <= left_q - 1'b1;
                        if (left_q == hbus_pkg::len_t'(1)) begin
                            state_q <= hbus_pkg::IDLE;
                        end
                    end else if (timeout) begin
                        state_q <= hbus_pkg::ERROR;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                hbus_pkg::WRITE: begin
                    state_q <= hbus_pkg::IDLE;
                end
                hbus_pkg::ERROR: begin
                    // Held until reset
                    state_q <= hbus_pkg::ERROR;
                end
                default: begin
                    state_q <= hbus_pkg::ERROR;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ca_q <= ca_init;
            wdata_q <= req_i.wdata;
        end else if (state_q == hbus_pkg::COMMAND) begin
            ca_q <= ca_q << 16;
        end
        if (strobe) begin
            rd_word_o <= pins_i.dq;
        end
    end

    // Pin decode, bus clock runs only while the device is selected
    always_comb begin
        pins_o = '0;
        pins_o.ck = clk & bus_active;
        pins_o.csn = !bus_active;
        pins_o.rstn = (state_q != hbus_pkg::RESET);
        case (state_q)
            hbus_pkg::COMMAND: begin
                pins_o.dq = ca_q[47:32];
                pins_o.dq_oe = 1'b1;
            end
            hbus_pkg::WRITE: begin
                pins_o.dq = wdata_q;
                pins_o.dq_oe = 1'b1;
                // No byte masked
                pins_o.rwds = 2'b00;
                pins_o.rwds_oe = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // Device owns DQ for the whole read phase
    a_no_dq_drive_in_read: assert property (
        @(posedge clk) disable iff (rst)
        (state_q == hbus_pkg::READ) |-> !pins_o.dq_oe
    ) else $error("dq driven during read");

    a_csn_high_when_idle: assert property (
        @(posedge clk) disable iff (rst)
        (state_q inside {hbus_pkg::RESET, hbus_pkg::IDLE, hbus_pkg::ERROR}) |-> pins_o.csn
    ) else $error("csn low outside a transaction");

endmodule

// File: source/hbus_rsp_merge.sv
// Per-channel read FIFOs and round-robin merge onto the response stream
`timescale 1ns/1ps

module hbus_rsp_merge (
    input  logic                          clk,
    input  logic                          rst,
    input  hbus_pkg::word_t               rd_word_i [hbus_pkg::NUM_CHAN],
    input  logic [hbus_pkg::NUM_CHAN-1:0] rd_valid_i,
    input  logic                          rsp_ready_i,
    output logic [hbus_pkg::NUM_CHAN-1:0] space_o,
    output hbus_pkg::hbus_rsp_t           rsp_o,
    output logic                          rsp_valid_o
);

    hbus_pkg::word_t               head [hbus_pkg::NUM_CHAN];
    logic [hbus_pkg::NUM_CHAN-1:0] empty;
    hbus_pkg::chan_t               last_q;
    hbus_pkg::chan_t               next;
    hbus_pkg::chan_t               sel;
    logic                          pop_any;

    // Prefer the channel not served last, fall back to the last one
    assign next = last_q + 1'b1;
    assign sel = empty[next] ? last_q : next;

    assign rsp_valid_o = !(&empty);
    assign rsp_o.chan = sel;
    assign rsp_o.data = head[sel];
    assign pop_any = rsp_valid_o && rsp_ready_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_q <= '0;
        end else if (pop_any) begin
            last_q <= sel;
        end
    end

    for (genvar g = 0; g < hbus_pkg::NUM_CHAN; g++) begin : g_fifo
        hbus_pkg::word_t mem [hbus_pkg::MAX_BURST];
        hbus_pkg::ptr_t  wr_ptr_q;
        hbus_pkg::ptr_t  rd_ptr_q;
        hbus_pkg::fill_t fill_q;
        logic            push;
        logic            pop;

        assign push = rd_valid_i[g];
        assign pop = pop_any && (sel == hbus_pkg::chan_t'(g));

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                wr_ptr_q <= '0;
                rd_ptr_q <= '0;
                fill_q <= '0;
            end else begin
                if (push) begin
                    wr_ptr_q <= wr_ptr_q + 1'b1;
                end
                if (pop) begin
                    rd_ptr_q <= rd_ptr_q + 1'b1;
                end
                fill_q <= fill_q + hbus_pkg::fill_t'(push) - hbus_pkg::fill_t'(pop);
            end
        end

        always_ff @(posedge clk) begin
            if (push) begin
                mem[wr_ptr_q] <= rd_word_i[g];
            end
        end

        assign head[g] = mem[rd_ptr_q];
        assign empty[g] = (fill_q == '0);
        // Only an empty FIFO is sure to hold a full burst
        assign space_o[g] = empty[g];

        // Controller has no ready, so the space rule must prevent overflow
        a_no_write_when_full: assert property (
            @(posedge clk) disable iff (rst)
            push |-> (fill_q != hbus_pkg::fill_t'(hbus_pkg::MAX_BURST))
        ) else $error("read FIFO written while full");
    end

endmodule

// File: source/hbus_subsystem_top.sv
// Two-channel HyperBus subsystem with dispatcher, channel controllers and merger
`timescale 1ns/1ps

module hbus_subsystem_top (
    input  logic                          clk,
    input  logic                          rst,
    input  hbus_pkg::hbus_req_t           req_i,
    input  logic                          req_valid_i,
    input  logic                          rsp_ready_i,
    input  hbus_pkg::hbus_pins_i_t        pins_i [hbus_pkg::NUM_CHAN],
    output logic                          req_ready_o,
    output hbus_pkg::hbus_rsp_t           rsp_o,
    output logic                          rsp_valid_o,
    output logic [hbus_pkg::NUM_CHAN-1:0] error_o,
    output hbus_pkg::hbus_pins_o_t        pins_o [hbus_pkg::NUM_CHAN]
);

    hbus_pkg::hbus_req_t           chan_req;
    logic [hbus_pkg::NUM_CHAN-1:0] chan_valid;
    logic [hbus_pkg::NUM_CHAN-1:0] chan_ready;
    logic [hbus_pkg::NUM_CHAN-1:0] space;
    logic [hbus_pkg::NUM_CHAN-1:0] rd_valid;
    hbus_pkg::word_t               rd_word [hbus_pkg::NUM_CHAN];

    hbus_req_dispatch i_dispatch (
        .clk          (clk),
        .rst          (rst),
        .req_i        (req_i),
        .req_valid_i  (req_valid_i),
        .chan_ready_i (chan_ready),
        .req_ready_o  (req_ready_o),
        .chan_req_o   (chan_req),
        .chan_valid_o (chan_valid)
    );

    for (genvar g = 0; g < hbus_pkg::NUM_CHAN; g++) begin : g_chan
        hbus_channel_ctrl i_ctrl (
            .clk         (clk),
            .rst         (rst),
            .req_i       (chan_req),
            .req_valid_i (chan_valid[g]),
            .space_i     (space[g]),
            .pins_i      (pins_i[g]),
            .req_ready_o (chan_ready[g]),
            .pins_o      (pins_o[g]),
            .rd_word_o   (rd_word[g]),
            .rd_valid_o  (rd_valid[g]),
            .error_o     (error_o[g])
        );
    end

    hbus_rsp_merge i_merge (
        .clk         (clk),
        .rst         (rst),
        .rd_word_i   (rd_word),
        .rd_valid_i  (rd_valid),
        .rsp_ready_i (rsp_ready_i),
        .space_o     (space),
        .rsp_o       (rsp_o),
        .rsp_valid_o (rsp_valid_o)
    );

endmodule

// File: testbench/hbus_ram_model.sv
// Behavioural HyperRAM for one channel with memory, register array, latency and mute
`timescale 1ns/1ps

module hbus_ram_model #(
    parameter hbus_pkg::chan_t CHAN = 1'b0
) (
    input  logic                   clk,
    input  hbus_pkg::hbus_pins_o_t bus_i,
    input  logic                   double_lat_i,
    input  logic                   mute_i,
    output hbus_pkg::hbus_pins_i_t bus_o
);

    hbus_pkg::word_t mem [256];
    hbus_pkg::word_t regs [16];
    logic [1:0]      beat_q;
    logic [47:0]     ca_q;
    logic [4:0]      wait_q;
    logic [7:0]      cnt_q;
    logic [7:0]      lfsr_q;
    logic [7:0]      idx;
    logic            in_data;
    logic            strobe;

    // Word index from the CA fields plus the words already sent
    assign idx = {ca_q[20:16], ca_q[2:0]} + cnt_q;
    assign in_data = !bus_i.csn && (beat_q == 2'd3) && (wait_q == 5'd0);
    // Roughly three strobes in four cycles, none at all when muted
    assign strobe = in_data && ca_q[47] && !mute_i && (lfsr_q[0] || lfsr_q[1]);

    always_comb begin
        bus_o.dq = ca_q[46] ? regs[idx[3:0]] : mem[idx];
        bus_o.rwds = strobe;
        // RWDS high during the command asks for double latency
        if (!bus_i.csn && (beat_q != 2'd3)) begin
            bus_o.rwds = double_lat_i;
        end
    end

    always_ff @(posedge clk) begin
        lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
        if (!bus_i.rstn) begin
            // Known contents after device reset
            for (int i = 0; i < 256; i++) begin
                mem[i] <= {4'hA, 3'd0, CHAN, 8'(i)};
            end
            for (int i = 0; i < 16; i++) begin
                regs[i] <= {4'hE, 7'd0, CHAN, 4'(i)};
            end
            lfsr_q <= 8'hA5;
            beat_q <= 2'd0;
            wait_q <= 5'd0;
            cnt_q <= 8'd0;
        end else if (bus_i.csn) begin
            beat_q <= 2'd0;
            wait_q <= 5'd0;
            cnt_q <= 8'd0;
        end else if ((beat_q != 2'd3) && bus_i.dq_oe) begin
            ca_q <= {ca_q[31:0], bus_i.dq};
            beat_q <= beat_q + 2'd1;
            if (beat_q == 2'd2) begin
                wait_q <= double_lat_i ? 5'(2 * hbus_pkg::TACC_COUNT)
                                       : 5'(hbus_pkg::TACC_COUNT);
            end
        end else if (wait_q != 5'd0) begin
            wait_q <= wait_q - 5'd1;
        end else if (bus_i.dq_oe && bus_i.rwds_oe) begin
            if (ca_q[46]) begin
                regs[idx[3:0]] <= bus_i.dq;
            end else begin
                mem[idx] <= bus_i.dq;
            end
        end else if (strobe) begin
            cnt_q <= cnt_q + 8'd1;
        end
    end

endmodule

// File: testbench/tb_hbus_top.sv
// Testbench for the two-channel HyperBus subsystem driven from a table of requests
`timescale 1ns/1ps

module tb_hbus_top;

    typedef struct packed {
        logic            write;
        logic            reg_space;
        hbus_pkg::addr_t addr;
        hbus_pkg::len_t  len;
        hbus_pkg::word_t wdata;
        logic [1:0]      dbl;
        logic [1:0]      mute;
    } row_t;

    logic                   clk;
    logic                   rst;
    hbus_pkg::hbus_req_t    req;
    logic                   req_valid;
    logic                   req_ready;
    logic                   rsp_ready;
    hbus_pkg::hbus_rsp_t    rsp;
    logic                   rsp_valid;
    logic [1:0]             error;
    logic [1:0]             dbl;
    logic [1:0]             mute;
    hbus_pkg::hbus_pins_o_t pins_o [hbus_pkg::NUM_CHAN];
    hbus_pkg::hbus_pins_i_t pins_i [hbus_pkg::NUM_CHAN];

    row_t            rows [$];
    string           names [$];
    hbus_pkg::word_t shadow_mem [hbus_pkg::NUM_CHAN][256];
    hbus_pkg::word_t shadow_reg [hbus_pkg::NUM_CHAN][16];
    hbus_pkg::word_t exp_word [hbus_pkg::NUM_CHAN][$];
    string           exp_name [hbus_pkg::NUM_CHAN][$];
    integer          seed = 32'hed6b_c0dc;
    integer          rnd;
    int              cycles = 0;
    int              limit;

    hbus_subsystem_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .req_i       (req),
        .req_valid_i (req_valid),
        .rsp_ready_i (rsp_ready),
        .pins_i      (pins_i),
        .req_ready_o (req_ready),
        .rsp_o       (rsp),
        .rsp_valid_o (rsp_valid),
        .error_o     (error),
        .pins_o      (pins_o)
    );

    hbus_ram_model #(.CHAN(1'b0)) i_ram0 (
        .clk          (clk),
        .bus_i        (pins_o[0]),
        .double_lat_i (dbl[0]),
        .mute_i       (mute[0]),
        .bus_o        (pins_i[0])
    );

    hbus_ram_model #(.CHAN(1'b1)) i_ram1 (
        .clk          (clk),
        .bus_i        (pins_o[1]),
        .double_lat_i (dbl[1]),
        .mute_i       (mute[1]),
        .bus_o        (pins_i[1])
    );

    always #5 clk = ~clk;

    // Random back-pressure on the response stream
    always @(posedge clk) begin
        #1;
        rnd = $random(seed);
        rsp_ready = (rnd[1:0] != 2'b00);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            stop_run("hang");
        end
    end

    // Handshake values are settled by the falling edge
    always @(negedge clk) begin
        if (!rst && rsp_valid && rsp_ready) begin
            take_response();
        end
    end

    task automatic stop_run(string why);
        $display("Simulation FAILED");
        $fatal(1, why);
    endtask

    task automatic check_word(string name, hbus_pkg::word_t exp, hbus_pkg::word_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, got %h", name, exp, act);
            stop_run("data mismatch");
        end
    endtask

    task automatic check_chan(string name, hbus_pkg::chan_t exp, hbus_pkg::chan_t act);
        if (act !== exp) begin
            $display("Fail %s: expected channel %0d, got %0d", name, exp, act);
            stop_run("channel mismatch");
        end
    endtask

    task automatic check_error(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("Fail %s: expected error %b, got %b", name, exp, act);
            stop_run("error flag mismatch");
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("Fail %s: expected %b, got %b", name, exp, act);
            stop_run("flag mismatch");
        end
    endtask

    task automatic take_response();
        hbus_pkg::chan_t c;
        hbus_pkg::word_t w;
        string           name;
        c = rsp.chan;
        if (exp_word[c].size() == 0 && exp_word[~c].size() == 0) begin
            $display("A response arrived while no read was outstanding");
            stop_run("unexpected response");
        end else if (exp_word[c].size() == 0) begin
            check_chan(exp_name[~c][0], ~c, c);
        end else begin
            w = exp_word[c].pop_front();
            name = exp_name[c].pop_front();
            check_word(name, w, rsp.data);
        end
    endtask

    task automatic add_row(string name, logic write, logic reg_space, hbus_pkg::addr_t addr,
                           int len, hbus_pkg::word_t wdata, logic [1:0] dbl_lat,
                           logic [1:0] mute_set);
        row_t r;
        r.write = write;
        r.reg_space = reg_space;
        r.addr = addr;
        r.len = hbus_pkg::len_t'(len);
        r.wdata = wdata;
        r.dbl = dbl_lat;
        r.mute = mute_set;
        rows.push_back(r);
        names.push_back(name);
    endtask

    // Shadow update for writes, expected words for reads
    task automatic predict(string name, row_t r);
        hbus_pkg::chan_t c;
        logic [7:0]      idx;
        int              n;
        c = r.addr[hbus_pkg::CHAN_SEL_BIT];
        idx = r.addr[7:0];
        n = int'(r.len);
        if (r.write && r.reg_space) begin
            shadow_reg[c][idx[3:0]] = r.wdata;
        end else if (r.write) begin
            shadow_mem[c][idx] = r.wdata;
        end else if (!r.mute[c]) begin
            for (int k = 0; k < n; k++) begin
                exp_name[c].push_back(name);
                if (r.reg_space) begin
                    exp_word[c].push_back(shadow_reg[c][4'(int'(idx) + k)]);
                end else begin
                    exp_word[c].push_back(shadow_mem[c][8'(int'(idx) + k)]);
                end
            end
        end
    endtask

    task automatic send_req(row_t r);
        @(posedge clk);
        #1;
        req.write = r.write;
        req.reg_space = r.reg_space;
        req.addr = r.addr;
        req.len = r.len;
        req.wdata = r.wdata;
        dbl = r.dbl;
        mute = r.mute;
        req_valid = 1'b1;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_word[0].size() != 0 || exp_word[1].size() != 0) begin
            @(negedge clk);
        end
    endtask

    initial begin
        hbus_pkg::chan_t c;
        clk = 1'b0;
        rst = 1'b1;
        req = '0;
        req_valid = 1'b0;
        rsp_ready = 1'b0;
        dbl = 2'b00;
        mute = 2'b00;

        // Same contents as the device after its reset
        for (int ch = 0; ch < hbus_pkg::NUM_CHAN; ch++) begin
            for (int i = 0; i < 256; i++) begin
                shadow_mem[ch][i] = {4'hA, 3'd0, 1'(ch), 8'(i)};
            end
            for (int i = 0; i < 16; i++) begin
                shadow_reg[ch][i] = {4'hE, 7'd0, 1'(ch), 4'(i)};
            end
        end

        //      name                          wr    reg   addr           len data     dbl    mute
        add_row("write ch0 word 0x10",        1'b1, 1'b0, 32'h0000_0010, 1, 16'h1234, 2'b00, 2'b00);
        add_row("write ch0 word 0x11",        1'b1, 1'b0, 32'h0000_0011, 1, 16'h5678, 2'b00, 2'b00);
        add_row("write ch1 word 0x20",        1'b1, 1'b0, 32'h0100_0020, 1, 16'h9abc, 2'b00, 2'b00);
        add_row("read ch0 burst",             1'b0, 1'b0, 32'h0000_0010, 4, 16'h0000, 2'b00, 2'b00);
        add_row("read ch1 full burst",        1'b0, 1'b0, 32'h0100_001e, 16, 16'h0000, 2'b00, 2'b00);
        add_row("write ch1 register 0x20",    1'b1, 1'b1, 32'h0100_0020, 1, 16'hc0de, 2'b00, 2'b00);
        add_row("read ch1 register",          1'b0, 1'b1, 32'h0100_0020, 2, 16'h0000, 2'b00, 2'b00);
        add_row("read ch1 memory under reg",  1'b0, 1'b0, 32'h0100_0020, 1, 16'h0000, 2'b00, 2'b00);
        add_row("read ch0 double latency",    1'b0, 1'b0, 32'h0000_0010, 3, 16'h0000, 2'b01, 2'b00);
        add_row("write ch1 double latency",   1'b1, 1'b0, 32'h0100_0031, 1, 16'h4321, 2'b10, 2'b00);
        add_row("interleave read ch0",        1'b0, 1'b0, 32'h0000_0040, 16, 16'h0000, 2'b00, 2'b00);
        add_row("interleave read ch1",        1'b0, 1'b0, 32'h0100_0028, 8, 16'h0000, 2'b00, 2'b00);
        add_row("interleave write ch0",       1'b1, 1'b0, 32'h0000_0041, 1, 16'hbeef, 2'b00, 2'b00);
        add_row("interleave read ch0 again",  1'b0, 1'b0, 32'h0000_0041, 2, 16'h0000, 2'b00, 2'b00);
        add_row("interleave read ch1 double", 1'b0, 1'b0, 32'h0100_0030, 5, 16'h0000, 2'b10, 2'b00);
        add_row("muted read ch1",             1'b0, 1'b0, 32'h0100_0000, 4, 16'h0000, 2'b00, 2'b10);
        add_row("read ch0 after ch1 error",   1'b0, 1'b0, 32'h0000_0000, 8, 16'h0000, 2'b00, 2'b10);
        limit = rows.size() * (40 + hbus_pkg::MAX_BURST * 4 + hbus_pkg::TIMEOUT_COUNT);

        // Both channels idle and the devices held in reset
        @(negedge clk);
        for (int k = 0; k < hbus_pkg::NUM_CHAN; k++) begin
            check_flag("reset rstn low", 1'b0, pins_o[k].rstn);
            check_flag("reset csn high", 1'b1, pins_o[k].csn);
            check_flag("reset dq_oe low", 1'b0, pins_o[k].dq_oe);
            check_flag("reset rwds_oe low", 1'b0, pins_o[k].rwds_oe);
            check_error("reset error low", 1'b0, error[k]);
        end
        check_flag("reset req_ready low", 1'b0, req_ready);
        check_flag("reset rsp_valid low", 1'b0, rsp_valid);
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        while (!req_ready) begin
            @(negedge clk);
        end
        for (int k = 0; k < hbus_pkg::NUM_CHAN; k++) begin
            check_flag("device reset released", 1'b1, pins_o[k].rstn);
            check_flag("csn high when idle", 1'b1, pins_o[k].csn);
        end

        foreach (rows[i]) begin
            c = rows[i].addr[hbus_pkg::CHAN_SEL_BIT];
            if (rows[i].mute != 2'b00) begin
                drain();
            end
            predict(names[i], rows[i]);
            send_req(rows[i]);
            if (rows[i].mute[c] && !rows[i].write) begin
                while (error[c] !== 1'b1) begin
                    @(negedge clk);
                end
                check_error(names[i], 1'b1, error[c]);
                check_error(names[i], 1'b0, error[~c]);
            end
        end

        drain();
        check_error("final error ch0", 1'b0, error[0]);
        check_error("final error ch1", 1'b1, error[1]);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: project.f
source/hbus_pkg.sv
source/hbus_req_dispatch.sv
source/hbus_channel_ctrl.sv
source/hbus_rsp_merge.sv
source/hbus_subsystem_top.sv
testbench/hbus_ram_model.sv
testbench/tb_hbus_top.sv

// File: Makefile
SIM := obj_dir/Vtb_hbus_top
SRCS := $(wildcard source/*.sv testbench/*.sv)

.PHONY: all run clean

all: run

$(SIM): project.f $(SRCS)
	verilator --binary --top-module tb_hbus_top -f project.f --Mdir obj_dir -o Vtb_hbus_top

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
